//--- Makefile
TOP = RamBlockTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- include/ram_params.svh
`ifndef RAM_PARAMS_SVH
`define RAM_PARAMS_SVH

// ----------------------------------------
// RAM pin side
// ----------------------------------------
// Parallel data bus width
`define RAM_DQ_WIDTH 16
// Word address width
`define RAM_ADRS_WIDTH 24

// ----------------------------------------
// Wishbone side
// ----------------------------------------
`define WB_ADRS_WIDTH 8
`define WB_DATA_WIDTH 32
// RAM clock divider after reset
`define CLKDIV_RESET 8'd1

`endif

//--- logic/DeviceCfg.sv
`timescale 1ns/1ps
`include "ram_params.svh"

module DeviceCfg (
	input  logic                     sClk,
	input  logic                     reset,
	input  logic                     cfgStart,
	input  logic [`RAM_DQ_WIDTH-1:0] cfgData,
	output logic                     cfgBusy,
	output logic                     cfgReq,
	output ramPkg::ramXfer_t         cfgXfer,
	input  ramPkg::ramRes_t          cfgRes
);
	import ramPkg::*;

	cfgState_t state;

	assign cfgBusy = (state != CFG_IDLE);

	// ----------------------------------------
	// Control FSM
	// ----------------------------------------
	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			state  <= CFG_IDLE;
			cfgReq <= 1'b0;
		end
		else
		begin
			case (state)
				CFG_IDLE:
				begin
					if (cfgStart)
						state <= CFG_REQ;
				end
				// Transfer word is loaded, raise the request
				CFG_REQ:
				begin
					cfgReq <= 1'b1;
					state  <= CFG_WAIT;
				end
				// Held until the port unit finishes
				CFG_WAIT:
				begin
					if (cfgRes.done)
					begin
						cfgReq <= 1'b0;
						state  <= CFG_IDLE;
					end
				end
				default: state <= CFG_IDLE;
			endcase
		end
	end

	// Mode word goes out with a zero address
	always_ff @(posedge sClk)
	begin
		if (state == CFG_IDLE && cfgStart)
			cfgXfer <= '{op: OP_CFG, adrs: '0, wd: cfgData};
	end

endmodule

//--- logic/MemoryAccessTester.sv
`timescale 1ns/1ps
`include "ram_params.svh"

module MemoryAccessTester (
	input  logic              sClk,
	input  logic              reset,
	input  ramPkg::testCtrl_t testCtrl,
	output ramPkg::testStat_t testStat,
	output logic              matReq,
	output ramPkg::ramXfer_t  matXfer,
	input  ramPkg::ramRes_t   matRes
);
	import ramPkg::*;

	matState_t                  state;
	logic [15:0]                idx;
	logic [`RAM_DQ_WIDTH-1:0]   patWord;
	logic [`RAM_ADRS_WIDTH-1:0] patAdrs;
	logic                       lastIdx;
	logic                       testDone;
	logic                       testErr;
	logic [15:0]                errCount;
	logic [`RAM_ADRS_WIDTH-1:0] errAdrs;
	logic [`RAM_DQ_WIDTH-1:0]   accRd;

	// Pattern and address follow the one index counter
	assign patWord = testCtrl.testPat + idx;
	assign patAdrs = testCtrl.testAdrs + `RAM_ADRS_WIDTH'(idx);
	assign lastIdx = (idx == testCtrl.testLen - 16'd1);

	assign testStat.testBusy = (state == MAT_WRITE) || (state == MAT_READ);
	assign testStat.accBusy  = (state == MAT_ACC);
	assign testStat.testDone = testDone;
	assign testStat.testErr  = testErr;
	assign testStat.errCount = errCount;
	assign testStat.errAdrs  = errAdrs;
	assign testStat.accRd    = accRd;

	// ----------------------------------------
	// Control FSM
	// ----------------------------------------
	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			state    <= MAT_IDLE;
			matReq   <= 1'b0;
			idx      <= '0;
			testDone <= 1'b0;
			testErr  <= 1'b0;
			errCount <= '0;
			errAdrs  <= '0;
		end
		else
		begin
			case (state)
				MAT_IDLE:
				begin
					// Single access wins over a test start
					if (testCtrl.accStart)
					begin
						matReq <= 1'b1;
						state  <= MAT_ACC;
					end
					else if (testCtrl.testStart)
					begin
						idx      <= '0;
						testDone <= 1'b0;
						testErr  <= 1'b0;
						errCount <= '0;
						state    <= MAT_WRITE;
					end
				end
				MAT_ACC:
				begin
					if (matRes.done)
					begin
						matReq <= 1'b0;
						state  <= MAT_IDLE;
					end
				end
				MAT_WRITE, MAT_READ:
				begin
					if (!matReq)
						matReq <= 1'b1;
					else if (matRes.done)
					begin
						matReq <= 1'b0;
						idx    <= lastIdx ? '0 : idx + 16'd1;
						// Compare on read back
						if (state == MAT_READ && matRes.rd != patWord)
						begin
							errCount <= errCount + 16'd1;
							testErr  <= 1'b1;
							if (errCount == '0)
								errAdrs <= matXfer.adrs;
						end
						if (lastIdx && state == MAT_WRITE)
							state <= MAT_READ;
						else if (lastIdx)
						begin
							testDone <= 1'b1;
							state    <= MAT_IDLE;
						end
					end
				end
				default: state <= MAT_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// Transfer word and read result
	// ----------------------------------------
	always_ff @(posedge sClk)
	begin
		if (state == MAT_IDLE && testCtrl.accStart)
			matXfer <= '{op: testCtrl.accWrite ? OP_WRITE : OP_READ,
				adrs: testCtrl.accAdrs, wd: testCtrl.accWd};
		else if (state == MAT_WRITE && !matReq)
			matXfer <= '{op: OP_WRITE, adrs: patAdrs, wd: patWord};
		else if (state == MAT_READ && !matReq)
			matXfer <= '{op: OP_READ, adrs: patAdrs, wd: '0};
		if (state == MAT_ACC && matRes.done && matXfer.op == OP_READ)
			accRd <= matRes.rd;
	end

endmodule

//--- logic/RamBlock.sv
`timescale 1ns/1ps
`include "ram_params.svh"

module RamBlock (
	input  logic                     sClk,
	input  logic                     reset,
	input  ramPkg::wbReq_t           wbReq,
	output ramPkg::wbResp_t          wbResp,
	output logic [`RAM_DQ_WIDTH-1:0] ramDqOut,
	input  logic [`RAM_DQ_WIDTH-1:0] ramDqIn,
	output logic                     ramDqOe,
	output logic                     ramClk,
	output logic                     ramCeN
);
	import ramPkg::*;

	// ----------------------------------------
	// Register file to engines
	// ----------------------------------------
	logic                     cfgStart;
	logic [`RAM_DQ_WIDTH-1:0] cfgData;
	logic                     cfgBusy;
	testCtrl_t                testCtrl;
	testStat_t                testStat;
	logic [7:0]               clkDiv;

	// Engines to port unit
	logic     cfgReq;
	ramXfer_t cfgXfer;
	ramRes_t  cfgRes;
	logic     matReq;
	ramXfer_t matXfer;
	ramRes_t  matRes;

	RamCsr RamCsr_i (
		.sClk(sClk),           .reset(reset),
		.wbReq(wbReq),         .wbResp(wbResp),
		.cfgStart(cfgStart),   .cfgData(cfgData),     .cfgBusy(cfgBusy),
		.testCtrl(testCtrl),   .testStat(testStat),   .clkDiv(clkDiv)
	);

	DeviceCfg DeviceCfg_i (
		.sClk(sClk),           .reset(reset),
		.cfgStart(cfgStart),   .cfgData(cfgData),     .cfgBusy(cfgBusy),
		.cfgReq(cfgReq),       .cfgXfer(cfgXfer),     .cfgRes(cfgRes)
	);

	MemoryAccessTester MemoryAccessTester_i (
		.sClk(sClk),           .reset(reset),
		.testCtrl(testCtrl),   .testStat(testStat),
		.matReq(matReq),       .matXfer(matXfer),     .matRes(matRes)
	);

	RamIfPortUnit RamIfPortUnit_i (
		.sClk(sClk),           .reset(reset),         .clkDiv(clkDiv),
		.cfgReq(cfgReq),       .cfgXfer(cfgXfer),     .cfgRes(cfgRes),
		.matReq(matReq),       .matXfer(matXfer),     .matRes(matRes),
		.ramDqOut(ramDqOut),   .ramDqIn(ramDqIn),     .ramDqOe(ramDqOe),
		.ramClk(ramClk),       .ramCeN(ramCeN)
	);

endmodule

//--- logic/RamCsr.sv
`timescale 1ns/1ps
`include "ram_params.svh"

module RamCsr (
	input  logic                     sClk,
	input  logic                     reset,
	input  ramPkg::wbReq_t           wbReq,
	output ramPkg::wbResp_t          wbResp,
	output logic                     cfgStart,
	output logic [`RAM_DQ_WIDTH-1:0] cfgData,
	input  logic                     cfgBusy,
	output ramPkg::testCtrl_t        testCtrl,
	input  ramPkg::testStat_t        testStat,
	output logic [7:0]               clkDiv
);
	import ramPkg::*;

	// Byte addresses of the register file
	localparam logic [`WB_ADRS_WIDTH-1:0] ADR_CTRL     = 8'h00;
	localparam logic [`WB_ADRS_WIDTH-1:0] ADR_STATUS   = 8'h04;
	localparam logic [`WB_ADRS_WIDTH-1:0] ADR_CLKDIV   = 8'h08;
	localparam logic [`WB_ADRS_WIDTH-1:0] ADR_CFGDATA  = 8'h0C;
	localparam logic [`WB_ADRS_WIDTH-1:0] ADR_TESTADRS = 8'h10;
	localparam logic [`WB_ADRS_WIDTH-1:0] ADR_TESTLEN  = 8'h14;
	localparam logic [`WB_ADRS_WIDTH-1:0] ADR_TESTPAT  = 8'h18;
	localparam logic [`WB_ADRS_WIDTH-1:0] ADR_ERRCOUNT = 8'h1C;
	localparam logic [`WB_ADRS_WIDTH-1:0] ADR_ERRADRS  = 8'h20;
	localparam logic [`WB_ADRS_WIDTH-1:0] ADR_ACCADRS  = 8'h24;
	localparam logic [`WB_ADRS_WIDTH-1:0] ADR_ACCWD    = 8'h28;
	localparam logic [`WB_ADRS_WIDTH-1:0] ADR_ACCRD    = 8'h2C;

	logic                      reqSeen;
	logic                      ctrlWrite;
	logic                      engineBusy;
	logic [`WB_DATA_WIDTH-1:0] rdMux;

	// New request while ack is low
	assign reqSeen = wbReq.cyc && wbReq.stb && !wbResp.ack;
	// CTRL write seen during its ack cycle, data still held by the master
	assign ctrlWrite = wbResp.ack && wbReq.cyc && wbReq.stb && wbReq.we
		&& (wbReq.adr == ADR_CTRL);
	// Test and single access share one engine
	assign engineBusy = testStat.testBusy || testStat.accBusy;

	// ----------------------------------------
	// Read mux
	// ----------------------------------------
	always_comb
	begin
		rdMux = '0;
		case (wbReq.adr)
			ADR_STATUS:
			begin
				rdMux[0] = cfgBusy;
				rdMux[1] = testStat.testBusy;
				rdMux[2] = testStat.accBusy;
				rdMux[3] = testStat.testDone;
				rdMux[4] = testStat.testErr;
			end
			ADR_CLKDIV:   rdMux[7:0] = clkDiv;
			ADR_CFGDATA:  rdMux[`RAM_DQ_WIDTH-1:0] = cfgData;
			ADR_TESTADRS: rdMux[`RAM_ADRS_WIDTH-1:0] = testCtrl.testAdrs;
			ADR_TESTLEN:  rdMux[15:0] = testCtrl.testLen;
			ADR_TESTPAT:  rdMux[`RAM_DQ_WIDTH-1:0] = testCtrl.testPat;
			ADR_ERRCOUNT: rdMux[15:0] = testStat.errCount;
			ADR_ERRADRS:  rdMux[`RAM_ADRS_WIDTH-1:0] = testStat.errAdrs;
			ADR_ACCADRS:  rdMux[`RAM_ADRS_WIDTH-1:0] = testCtrl.accAdrs;
			ADR_ACCWD:    rdMux[`RAM_DQ_WIDTH-1:0] = testCtrl.accWd;
			ADR_ACCRD:    rdMux[`RAM_DQ_WIDTH-1:0] = testStat.accRd;
			default:      rdMux = '0;
		endcase
	end

	// Read data captured together with ack
	always_ff @(posedge sClk)
	begin
		if (reqSeen)
			wbResp.datR <= rdMux;
	end

	// ----------------------------------------
	// Ack, registers, start pulses
	// ----------------------------------------
	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			wbResp.ack         <= 1'b0;
			cfgStart           <= 1'b0;
			cfgData            <= '0;
			clkDiv             <= `CLKDIV_RESET;
			testCtrl.testStart <= 1'b0;
			testCtrl.testAdrs  <= '0;
			testCtrl.testLen   <= 16'd1;
			testCtrl.testPat   <= '0;
			testCtrl.accStart  <= 1'b0;
			testCtrl.accWrite  <= 1'b0;
			testCtrl.accAdrs   <= '0;
			testCtrl.accWd     <= '0;
		end
		else
		begin
			wbResp.ack <= reqSeen;
			// Starts dropped while the target is busy
			cfgStart           <= ctrlWrite && wbReq.datW[0] && !cfgBusy;
			testCtrl.testStart <= ctrlWrite && wbReq.datW[1] && !engineBusy;
			testCtrl.accStart  <= ctrlWrite && wbReq.datW[2] && !engineBusy;
			if (ctrlWrite && wbReq.datW[2] && !engineBusy)
				testCtrl.accWrite <= wbReq.datW[3];
			if (reqSeen && wbReq.we)
			begin
				case (wbReq.adr)
					ADR_CLKDIV:   clkDiv <= wbReq.datW[7:0];
					ADR_CFGDATA:  cfgData <= wbReq.datW[`RAM_DQ_WIDTH-1:0];
					ADR_TESTADRS: testCtrl.testAdrs <= wbReq.datW[`RAM_ADRS_WIDTH-1:0];
					ADR_TESTLEN:  testCtrl.testLen <= wbReq.datW[15:0];
					ADR_TESTPAT:  testCtrl.testPat <= wbReq.datW[`RAM_DQ_WIDTH-1:0];
					ADR_ACCADRS:  testCtrl.accAdrs <= wbReq.datW[`RAM_ADRS_WIDTH-1:0];
					ADR_ACCWD:    testCtrl.accWd <= wbReq.datW[`RAM_DQ_WIDTH-1:0];
					default:      ;
				endcase
			end
		end
	end

endmodule

//--- logic/RamIfPortUnit.sv
`timescale 1ns/1ps
`include "ram_params.svh"

module RamIfPortUnit (
	input  logic                     sClk,
	input  logic                     reset,
	input  logic [7:0]               clkDiv,
	input  logic                     cfgReq,
	input  ramPkg::ramXfer_t         cfgXfer,
	output ramPkg::ramRes_t          cfgRes,
	input  logic                     matReq,
	input  ramPkg::ramXfer_t         matXfer,
	output ramPkg::ramRes_t          matRes,
	output logic [`RAM_DQ_WIDTH-1:0] ramDqOut,
	input  logic [`RAM_DQ_WIDTH-1:0] ramDqIn,
	output logic                     ramDqOe,
	output logic                     ramClk,
	output logic                     ramCeN
);
	import ramPkg::*;

	ifState_t                 state;
	logic                     gntCfg;
	logic [7:0]               phaseCnt;
	logic                     phaseEnd;
	logic                     riseEdge;
	logic                     fallEdge;
	logic                     xferDone;
	logic [`RAM_DQ_WIDTH-1:0] rdReg;
	ramXfer_t                 cur;

	// Command word, address byte forced to zero for cfg
	function automatic logic [`RAM_DQ_WIDTH-1:0] cmdWord(input ramXfer_t x);
		cmdWord = {x.op, (x.op == OP_CFG) ? 8'h00 : x.adrs[23:16]};
	endfunction

	// Grant locked until the state machine is back in idle
	assign cur      = gntCfg ? cfgXfer : matXfer;
	// RAM clock only runs during a transfer and its gap
	assign phaseEnd = (state != IF_IDLE) && (phaseCnt == clkDiv);
	assign riseEdge = phaseEnd && !ramClk;
	assign fallEdge = phaseEnd && ramClk;
	assign xferDone = fallEdge && (state == IF_GAP);

	assign cfgRes.done = xferDone && gntCfg;
	assign cfgRes.rd   = rdReg;
	assign matRes.done = xferDone && !gntCfg;
	assign matRes.rd   = rdReg;

	// ----------------------------------------
	// Phase counter and word sequencer
	// ----------------------------------------
	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			state    <= IF_IDLE;
			gntCfg   <= 1'b0;
			phaseCnt <= '0;
			ramClk   <= 1'b0;
			ramCeN   <= 1'b1;
			ramDqOe  <= 1'b0;
		end
		else
		begin
			phaseCnt <= (state == IF_IDLE || phaseEnd) ? '0 : phaseCnt + 8'd1;
			if (phaseEnd)
				ramClk <= !ramClk;
			case (state)
				IF_IDLE:
				begin
					// Fixed priority, cfg first
					if (cfgReq || matReq)
					begin
						gntCfg  <= cfgReq;
						ramCeN  <= 1'b0;
						ramDqOe <= 1'b1;
						state   <= IF_CMD;
					end
				end
				IF_CMD:
				begin
					if (fallEdge)
						state <= (cur.op == OP_CFG) ? IF_DATA : IF_ADRS;
				end
				IF_ADRS:
				begin
					if (fallEdge)
					begin
						ramDqOe <= (cur.op != OP_READ);
						state   <= (cur.op == OP_READ) ? IF_TURN : IF_DATA;
					end
				end
				IF_TURN:
				begin
					if (fallEdge)
						state <= IF_DATA;
				end
				IF_DATA:
				begin
					if (fallEdge)
					begin
						ramCeN  <= 1'b1;
						ramDqOe <= 1'b0;
						state   <= IF_GAP;
					end
				end
				// One full ramClk period with chip enable high
				IF_GAP:
				begin
					if (fallEdge)
						state <= IF_IDLE;
				end
				default: state <= IF_IDLE;
			endcase
		end
	end

	// Output word changes on the falling edge, read word sampled on the rising edge
	always_ff @(posedge sClk)
	begin
		if (state == IF_IDLE)
			ramDqOut <= cfgReq ? cmdWord(cfgXfer) : cmdWord(matXfer);
		else if (fallEdge && state == IF_CMD)
			ramDqOut <= (cur.op == OP_CFG) ? cur.wd : cur.adrs[15:0];
		else if (fallEdge && state == IF_ADRS)
			ramDqOut <= cur.wd;
		if (riseEdge && state == IF_DATA && cur.op == OP_READ)
			rdReg <= ramDqIn;
	end

endmodule

//--- logic/ramPkg.sv
`include "ram_params.svh"

package ramPkg;

	// RAM command opcodes, sent in the high byte of the command word
	typedef enum logic [7:0]
	{
		OP_WRITE = 8'h02,
		OP_READ  = 8'h03,
		OP_CFG   = 8'hC0
	} ramOp_t;

	// ----------------------------------------
	// Wishbone classic
	// ----------------------------------------
	typedef struct packed
	{
		logic                      cyc;
		logic                      stb;
		logic                      we;
		logic [`WB_ADRS_WIDTH-1:0] adr;
		logic [`WB_DATA_WIDTH-1:0] datW;
	} wbReq_t;

	typedef struct packed
	{
		logic                      ack;
		logic [`WB_DATA_WIDTH-1:0] datR;
	} wbResp_t;

	// ----------------------------------------
	// Transfer request and result
	// ----------------------------------------
	typedef struct packed
	{
		ramOp_t                     op;
		logic [`RAM_ADRS_WIDTH-1:0] adrs;
		logic [`RAM_DQ_WIDTH-1:0]   wd;
	} ramXfer_t;

	typedef struct packed
	{
		logic                     done;
		logic [`RAM_DQ_WIDTH-1:0] rd;
	} ramRes_t;

	// Register file to tester
	typedef struct packed
	{
		logic                       testStart;
		logic [`RAM_ADRS_WIDTH-1:0] testAdrs;
		logic [15:0]                testLen;
		logic [`RAM_DQ_WIDTH-1:0]   testPat;
		logic                       accStart;
		logic                       accWrite;
		logic [`RAM_ADRS_WIDTH-1:0] accAdrs;
		logic [`RAM_DQ_WIDTH-1:0]   accWd;
	} testCtrl_t;

	// Tester back to register file
	typedef struct packed
	{
		logic                       testBusy;
		logic                       accBusy;
		logic                       testDone;
		logic                       testErr;
		logic [15:0]                errCount;
		logic [`RAM_ADRS_WIDTH-1:0] errAdrs;
		logic [`RAM_DQ_WIDTH-1:0]   accRd;
	} testStat_t;

	// ----------------------------------------
	// FSM states
	// ----------------------------------------
	typedef enum logic [1:0] {CFG_IDLE, CFG_REQ, CFG_WAIT} cfgState_t;
	typedef enum logic [1:0] {MAT_IDLE, MAT_ACC, MAT_WRITE, MAT_READ} matState_t;
	typedef enum logic [2:0] {IF_IDLE, IF_CMD, IF_ADRS, IF_TURN, IF_DATA, IF_GAP} ifState_t;

endpackage

//--- tb.f
+incdir+include
logic/ramPkg.sv
logic/RamCsr.sv
logic/DeviceCfg.sv
logic/MemoryAccessTester.sv
logic/RamIfPortUnit.sv
logic/RamBlock.sv
test/PsramModel.sv
test/RamBlock_properties.sv
test/RamBlockTb.sv

//--- test/PsramModel.sv
`timescale 1ns/1ps
`include "ram_params.svh"

module PsramModel (
	input  logic                      ramClk,
	input  logic                      ramCeN,
	input  logic [`RAM_DQ_WIDTH-1:0]  ramDqOut,
	input  logic                      ramDqOe,
	output logic [`RAM_DQ_WIDTH-1:0]  ramDqIn,
	input  logic                      faultEn,
	input  logic [`RAM_ADRS_WIDTH-1:0] faultAdrs,
	output logic [`RAM_DQ_WIDTH-1:0]  modeReg
);

	logic [`RAM_DQ_WIDTH-1:0]   mem [logic [`RAM_ADRS_WIDTH-1:0]];
	logic [`RAM_DQ_WIDTH-1:0]   cmd;
	logic [`RAM_ADRS_WIDTH-1:0] adrs;
	int                         wordIdx;

	// Unwritten words read as zero
	function automatic logic [`RAM_DQ_WIDTH-1:0] fetchWord(input logic [`RAM_ADRS_WIDTH-1:0] a);
		logic [`RAM_DQ_WIDTH-1:0] w;
		w = mem.exists(a) ? mem[a] : '0;
		// Stuck bit at the fault address
		if (faultEn && a == faultAdrs)
			w[0] = ~w[0];
		return w;
	endfunction

	initial
	begin
		ramDqIn = '0;
		modeReg = '0;
		cmd     = '0;
		adrs    = '0;
		wordIdx = 0;
	end

	// Word sequence sampled on each rising ramClk edge
	always @(posedge ramClk)
	begin
		if (ramCeN)
			wordIdx = 0;
		else
		begin
			case (wordIdx)
				0: cmd = ramDqOut;
				1:
				begin
					// Mode word follows a cfg command
					if (cmd[15:8] == 8'hC0)
						modeReg = ramDqOut;
					else
						adrs = {cmd[7:0], ramDqOut};
				end
				2:
				begin
					if (cmd[15:8] == 8'h02 && ramDqOe)
						mem[adrs] = ramDqOut;
					// Turnaround period, data ready before the next rise
					else if (cmd[15:8] == 8'h03)
						ramDqIn <= fetchWord(adrs);
				end
				default: ;
			endcase
			wordIdx = wordIdx + 1;
		end
	end

endmodule

//--- test/RamBlockTb.sv
`timescale 1ns/1ps
`include "ram_params.svh"

module RamBlockTb;
	import ramPkg::*;

	localparam int CYCLE_LIMIT = 20000;

	logic                       sClk;
	logic                       reset;
	wbReq_t                     wbReq;
	wbResp_t                    wbResp;
	logic [`RAM_DQ_WIDTH-1:0]   ramDqOut;
	logic [`RAM_DQ_WIDTH-1:0]   ramDqIn;
	logic                       ramDqOe;
	logic                       ramClk;
	logic                       ramCeN;
	logic                       faultEn;
	logic [`RAM_ADRS_WIDTH-1:0] faultAdrs;
	logic [`RAM_DQ_WIDTH-1:0]   modeReg;
	integer                     seed;
	int                         cycleCount;
	int                         ackCount;
	logic [`RAM_DQ_WIDTH-1:0]   shadow [logic [`RAM_ADRS_WIDTH-1:0]];

	RamBlock RamBlock_i (
		.sClk(sClk),         .reset(reset),
		.wbReq(wbReq),       .wbResp(wbResp),
		.ramDqOut(ramDqOut), .ramDqIn(ramDqIn),   .ramDqOe(ramDqOe),
		.ramClk(ramClk),     .ramCeN(ramCeN)
	);

	PsramModel PsramModel_i (
		.ramClk(ramClk),     .ramCeN(ramCeN),     .ramDqOut(ramDqOut),
		.ramDqOe(ramDqOe),   .ramDqIn(ramDqIn),
		.faultEn(faultEn),   .faultAdrs(faultAdrs), .modeReg(modeReg)
	);

	initial
	begin
		sClk = 1'b0;
		forever #10 sClk = ~sClk;
	end

	// ----------------------------------------
	// Monitors
	// ----------------------------------------
	always @(posedge sClk)
	begin
		cycleCount <= cycleCount + 1;
		if (wbResp.ack)
			ackCount <= ackCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("Timeout: no completion within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	// Pattern rule wraps at 16 bits
	function automatic logic [15:0] patternWord(input logic [15:0] pat, input int i);
		return pat + i[15:0];
	endfunction

	// One error when the faulty word lies in the range
	function automatic int expectedErrors(input logic en, input logic [23:0] fAdrs,
		input logic [23:0] base, input int len);
		return (en && fAdrs >= base && fAdrs < base + len) ? 1 : 0;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// ----------------------------------------
	// Wishbone classic
	// ----------------------------------------
	task automatic wbAccess(input logic we, input logic [7:0] adr, input logic [31:0] datW,
		output logic [31:0] datR);
		int acksBefore;
		acksBefore = ackCount;
		@(posedge sClk);
		wbReq <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, datW: datW};
		do
			@(posedge sClk);
		while (!wbResp.ack);
		datR = wbResp.datR;
		wbReq <= '0;
		@(posedge sClk);
		checkValue("single ack", 32'd1, ackCount - acksBefore);
	endtask

	task automatic wbWrite(input logic [7:0] adr, input logic [31:0] datW);
		logic [31:0] unused;
		wbAccess(1'b1, adr, datW, unused);
	endtask

	task automatic wbRead(input logic [7:0] adr, output logic [31:0] datR);
		wbAccess(1'b0, adr, 32'h0, datR);
	endtask

	// Poll STATUS until the masked busy bits clear
	task automatic waitIdle(input logic [31:0] mask);
		logic [31:0] st;
		do
			wbRead(8'h04, st);
		while ((st & mask) != 0);
	endtask

	task automatic singleWrite(input logic [23:0] adrs, input logic [15:0] data);
		wbWrite(8'h24, adrs);
		wbWrite(8'h28, data);
		wbWrite(8'h00, 32'hC);
		waitIdle(32'h4);
		shadow[adrs] = data;
	endtask

	task automatic singleRead(input logic [23:0] adrs, output logic [31:0] data);
		wbWrite(8'h24, adrs);
		wbWrite(8'h00, 32'h4);
		waitIdle(32'h4);
		wbRead(8'h2C, data);
	endtask

	// Run the tester and compare its results
	task automatic patternTest(input logic [23:0] base, input int len, input logic [15:0] pat);
		logic [31:0] v;
		int errs;
		errs = expectedErrors(faultEn, faultAdrs, base, len);
		wbWrite(8'h10, base);
		wbWrite(8'h14, len);
		wbWrite(8'h18, pat);
		wbWrite(8'h00, 32'h2);
		// Running test with the previous done flag cleared
		wbRead(8'h04, v);
		checkValue("testBusy at start", 32'd1, v[1]);
		checkValue("testDone cleared", 32'd0, v[3]);
		waitIdle(32'h2);
		for (int i = 0; i < len; i++)
			shadow[base + i] = patternWord(pat, i);
		wbRead(8'h04, v);
		checkValue("testDone", 32'd1, v[3]);
		checkValue("testErr", (errs != 0), v[4]);
		wbRead(8'h1C, v);
		checkValue("ERRCOUNT", errs, v);
		if (errs != 0)
		begin
			wbRead(8'h20, v);
			checkValue("ERRADRS", faultAdrs, v);
		end
	endtask

	// Single access and pattern runs at one divider
	task automatic runSuite(input logic [7:0] div);
		logic [23:0] adrsList [6];
		logic [23:0] base;
		logic [31:0] v;
		int off;
		wbWrite(8'h08, div);
		wbRead(8'h08, v);
		checkValue("CLKDIV", div, v);
		for (int i = 0; i < 6; i++)
		begin
			adrsList[i] = $random(seed);
			singleWrite(adrsList[i], $random(seed));
		end
		for (int i = 0; i < 6; i++)
		begin
			singleRead(adrsList[i], v);
			checkValue("single access", shadow[adrsList[i]], v);
		end
		base = $random(seed) & 24'hFFF000;
		patternTest(base, 32, $random(seed));
		for (int i = 0; i < 4; i++)
		begin
			off = $unsigned($random(seed)) % 32;
			singleRead(base + off, v);
			checkValue("pattern word", shadow[base + off], v);
		end
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		logic [31:0] v;
		logic [23:0] base;
		seed       = 32'h7ee54ee9;
		cycleCount = 0;
		ackCount   = 0;
		reset      = 1'b1;
		wbReq      = '0;
		faultEn    = 1'b0;
		faultAdrs  = '0;
		repeat (10) @(posedge sClk);
		reset <= 1'b0;

		// Register readback
		wbWrite(8'h08, 32'h5A);
		wbRead(8'h08, v);
		checkValue("CLKDIV readback", 32'h5A, v);
		wbWrite(8'h08, 32'h1);
		wbWrite(8'h10, 32'h123456);
		wbRead(8'h10, v);
		checkValue("TESTADRS readback", 32'h123456, v);
		wbWrite(8'h14, 32'h7);
		wbRead(8'h14, v);
		checkValue("TESTLEN readback", 32'h7, v);
		wbWrite(8'h18, 32'hBEEF);
		wbRead(8'h18, v);
		checkValue("TESTPAT readback", 32'hBEEF, v);
		wbWrite(8'h28, 32'h1234);
		wbRead(8'h28, v);
		checkValue("ACCWD readback", 32'h1234, v);
		wbWrite(8'h30, 32'hFFFFFFFF);
		wbRead(8'h30, v);
		checkValue("unmapped 30h", 32'h0, v);
		wbRead(8'hFC, v);
		checkValue("unmapped FCh", 32'h0, v);
		wbRead(8'h04, v);
		checkValue("STATUS idle", 32'h0, v);

		// Mode register write
		wbWrite(8'h0C, 32'hA5C3);
		wbWrite(8'h00, 32'h1);
		waitIdle(32'h1);
		checkValue("mode register", 32'hA5C3, modeReg);

		runSuite(8'd1);
		runSuite(8'd0);
		runSuite(8'd3);

		// Fault on one word of the range
		wbWrite(8'h08, 32'h1);
		base = $random(seed) & 24'hFFF000;
		@(posedge sClk);
		faultEn   <= 1'b1;
		faultAdrs <= base + 24'd5;
		@(posedge sClk);
		patternTest(base, 16, $random(seed));
		@(posedge sClk);
		faultEn <= 1'b0;
		@(posedge sClk);

		// Clean rerun clears the error results
		patternTest(base, 16, $random(seed));

		@(posedge sClk);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- test/RamBlock_properties.sv
`timescale 1ns/1ps

module RamBlock_properties (
	input logic            sClk,
	input logic            reset,
	input ramPkg::wbReq_t  wbReq,
	input ramPkg::wbResp_t wbResp,
	input logic            ramDqOe,
	input logic            ramClk,
	input logic            ramCeN,
	input logic [7:0]      clkDiv
);

	// Cycles spent with ramClk high
	logic [8:0] highCnt;
	// Cycles spent with ramClk low while selected
	logic [8:0] lowCnt;

	always_ff @(posedge sClk)
	begin
		if (reset || !ramClk)
			highCnt <= '0;
		else
			highCnt <= highCnt + 9'd1;
	end

	always_ff @(posedge sClk)
	begin
		if (reset || ramClk || ramCeN)
			lowCnt <= '0;
		else
			lowCnt <= lowCnt + 9'd1;
	end

	// No drive on the data pins while deselected
	dqOffWhenIdle: assert property (@(posedge sClk) disable iff (reset) ramCeN |-> !ramDqOe)
		else $error("ramDqOe high while ramCeN high");

	ackOneCycle: assert property (@(posedge sClk) disable iff (reset) wbResp.ack |=> !wbResp.ack)
		else $error("ack longer than one cycle");

	ackAfterReq: assert property (@(posedge sClk) disable iff (reset)
		wbResp.ack |-> $past(wbReq.cyc && wbReq.stb))
		else $error("ack without a request");

	ceHighAfterReset: assert property (@(posedge sClk) reset |=> ramCeN)
		else $error("ramCeN low after reset");

	// High phase is always a full phase
	phaseLength: assert property (@(posedge sClk) disable iff (reset)
		$fell(ramClk) |-> (highCnt == {1'b0, clkDiv} + 9'd1))
		else $error("ramClk phase length wrong");

	// Low phase of each word while the chip is selected
	lowPhaseLength: assert property (@(posedge sClk) disable iff (reset)
		$rose(ramClk) && !ramCeN |-> (lowCnt == {1'b0, clkDiv} + 9'd1))
		else $error("ramClk low phase length wrong");

endmodule

bind RamBlock RamBlock_properties RamBlock_properties_i (
	.sClk(sClk),       .reset(reset),
	.wbReq(wbReq),     .wbResp(wbResp),
	.ramDqOe(ramDqOe), .ramClk(ramClk),     .ramCeN(ramCeN),
	.clkDiv(clkDiv)
);
